/* verilog.f */
+incdir+hw
hw/scv_map_pkg.sv
hw/scv_init_pkg.sv
hw/cpu_bus_if.sv
hw/scv_clkgen.sv
hw/scv_bus_ctrl.sv
hw/scv_decode.sv
hw/scv_rom.sv
hw/scv_wram.sv
hw/scv_top.sv
dv/scv_assertions.sv
dv/tb_top.sv

/* Makefile */
# Verilator flow for the SCV memory bus subsystem
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o sim_$(TOP)
	@out="$$(./$(OBJ_DIR)/sim_$(TOP) $(SIM_ARGS) 2>&1)"; echo "$$out"; \
	  echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* dv/tb_top.sv */
////////////////////////////////////////
// Testbench for the SCV memory bus subsystem
// Immediate asserts check read data, bound asserts check timing
// The run stops at the first failed check
////////////////////////////////////////

`timescale 1ns/1ps

`include "scv_cfg.svh"

module tb_clk (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o   = 1'b0;
    rst_n_o = 1'b0;
    forever #4 clk_o = ~clk_o;  // 8 ns period
  end

  initial begin
    repeat (3) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;  // Released away from the sampling edge
  end

endmodule

module tb_top;

  import scv_init_pkg::*;

  localparam int TIMEOUT = 100;

  logic           CLK, rst_n, req, we, ack, init_valid, vdc_ce;
  logic [15:0]    addr, a;
  logic [7:0]     wdata, rdata, init_data, d;
  scv_init_sel_e  init_sel;
  scv_init_addr_t init_addr;
  logic [31:0]    seed = 32'h671e_8c50;
  logic [15:0]    addr_q [$];
  int             hold_cycles = 0;  // Extra cycles req stays high after ack

  // Reference images
  logic [7:0] boot_m [1 << `SCV_BOOT_AW];
  logic [7:0] cart_m [1 << `SCV_CART_AW];
  logic [7:0] wram_m [1 << `SCV_WRAM_AW] = '{default: 8'h00};  // WRAM powers up at zero

  tb_clk u_clk (.clk_o(CLK), .rst_n_o(rst_n));

  scv_top dut0 (
    .CLK, .rst_n_i(rst_n), .req_i(req), .we_i(we), .addr_i(addr), .wdata_i(wdata),
    .ack_o(ack), .rdata_o(rdata), .init_sel_i(init_sel), .init_addr_i(init_addr),
    .init_data_i(init_data), .init_valid_i(init_valid), .vdc_ce_o(vdc_ce)
  );

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("test failed");
    $fatal(1, "stopping on first error");
  endtask

  task automatic init_write(input scv_init_sel_e sel, input logic [16:0] ia,
                            input logic [7:0] id);
    @(negedge CLK);
    init_sel   = sel;
    init_addr  = ia;
    init_data  = id;
    init_valid = 1'b1;
    @(negedge CLK);
    init_valid = 1'b0;
    init_sel   = INIT_NONE;
  endtask

  // One four-phase access
  task automatic bus_access(input string name, input logic w, input logic [15:0] ba,
                            input logic [7:0] bd, output logic [7:0] rd);
    int n;
    @(negedge CLK);
    addr  = ba;
    we    = w;
    wdata = bd;
    req   = 1'b1;
    n     = 0;
    while (!ack) begin
      if (n == TIMEOUT) fail_run({"timeout waiting for ack to rise in ", name});
      @(negedge CLK);
      n++;
    end
    rd  = rdata;
    repeat (hold_cycles) @(negedge CLK);  // Host stalls the bus
    req = 1'b0;
    n   = 0;
    while (ack) begin
      if (n == TIMEOUT) fail_run({"timeout waiting for ack to fall in ", name});
      @(negedge CLK);
      n++;
    end
  endtask

  task automatic write_byte(input string name, input logic [15:0] wa, input logic [7:0] wd);
    logic [7:0] unused;
    bus_access(name, 1'b1, wa, wd, unused);
  endtask

  task automatic read_check(input string name, input logic [15:0] ra, input logic [7:0] exp);
    logic [7:0] got;
    bus_access(name, 1'b0, ra, 8'h00, got);
    assert (got === exp)
      else fail_run($sformatf("MISMATCH %s: expected %02h, actual %02h", name, exp, got));
  endtask

  // Bound timing checks
  always @(negedge CLK) begin
    if (dut0.u_sva.err_cnt != 0) fail_run("a bound timing assertion failed");
  end

  initial begin
    req        = 1'b0;
    we         = 1'b0;
    addr       = '0;
    wdata      = '0;
    init_sel   = INIT_NONE;
    init_addr  = '0;
    init_data  = '0;
    init_valid = 1'b0;
    repeat (5) @(negedge CLK);

    ////////////////////////////////////////
    // Boot ROM
    ////////////////////////////////////////
    for (int i = 0; i < 64; i++) begin
      a = 16'(next_rand() >> 16) & 16'h0FFF;
      d = 8'(next_rand() >> 24);
      boot_m[a[11:0]] = d;
      addr_q.push_back(a);
      init_write(INIT_BOOT, {5'b0, a[11:0]}, d);
    end
    foreach (addr_q[i]) read_check("boot", addr_q[i], boot_m[addr_q[i][11:0]]);
    write_byte("boot_wr", addr_q[0], ~boot_m[addr_q[0][11:0]]);  // Must be ignored
    read_check("boot_wr", addr_q[0], boot_m[addr_q[0][11:0]]);

    ////////////////////////////////////////
    // Cartridge ROM
    ////////////////////////////////////////
    addr_q.delete();
    for (int i = 0; i < 64; i++) begin
      a = 16'h8000 | (16'(next_rand() >> 16) & 16'h7FFF);
      if (a >= 16'hFF80) a = a - 16'h0080;  // Keep clear of WRAM
      d = 8'(next_rand() >> 24);
      cart_m[a[14:0]] = d;
      addr_q.push_back(a);
      init_write(INIT_CART, {2'b0, a[14:0]}, d);
    end
    foreach (addr_q[i]) read_check("cart", addr_q[i], cart_m[addr_q[i][14:0]]);
    write_byte("cart_wr", addr_q[0], ~cart_m[addr_q[0][14:0]]);
    read_check("cart_wr", addr_q[0], cart_m[addr_q[0][14:0]]);

    // Work RAM, last write wins
    for (int i = 0; i < 40; i++) begin
      a = 16'hFF80 | (16'(next_rand() >> 16) & 16'h007F);
      d = 8'(next_rand() >> 24);
      wram_m[a[6:0]] = d;
      write_byte("wram", a, d);
    end
    for (int i = 0; i < 128; i++) read_check("wram", 16'hFF80 + 16'(i), wram_m[7'(i)]);

    // Req held high past ack
    hold_cycles = 6;
    read_check("stall", 16'hFF80, wram_m[0]);
    hold_cycles = 0;

    // Open bus in unmapped and video space
    write_byte("vram_wr", 16'h2000, 8'h5A);
    for (int i = 0; i < 4; i++) begin
      read_check("open_1000", 16'h1000 | (16'(next_rand() >> 16) & 16'h0FFF), 8'hFF);
      read_check("open_2000", 16'h2000 | (16'(next_rand() >> 16) & 16'h1FFF), 8'hFF);
      read_check("open_4000", 16'h4000 | (16'(next_rand() >> 16) & 16'h3FFF), 8'hFF);
    end

    repeat (4) @(negedge CLK);
    if (dut0.u_sva.err_cnt != 0) begin
      fail_run("a bound timing assertion failed");
    end else begin
      $display("test passed");
      $finish;
    end
  end

endmodule

/* dv/scv_assertions.sv */
////////////////////////////////////////
// Handshake and video enable checks, bound into scv_top
// err_cnt holds the number of failed checks
////////////////////////////////////////

`timescale 1ns/1ps

module scv_assertions (
  input logic CLK,
  input logic rst_n_i,
  input logic req_i,
  input logic ack_i,
  input logic vdc_ce_i
);

  int unsigned err_cnt = 0;
  logic [3:0]  since;  // Cycles since the last video enable
  logic        seen;

  always_ff @(posedge CLK or negedge rst_n_i) begin
    if (!rst_n_i) begin
      since <= '0;
      seen  <= 1'b0;
    end else if (vdc_ce_i) begin
      since <= 4'd1;
      seen  <= 1'b1;
    end else begin
      since <= since + 4'd1;
    end
  end

  ////////////////////////////////////////
  // Four-phase handshake
  ////////////////////////////////////////
  ack_low_after_reset: assert property (@(posedge CLK) $rose(rst_n_i) |-> !ack_i)
    else begin
      err_cnt++;
      $error("ack high right after reset");
    end

  // The rise is seen one sample after the edge that made it
  ack_rise_needs_req: assert property (@(posedge CLK) disable iff (!rst_n_i)
    $rose(ack_i) |-> $past(req_i))
    else begin
      err_cnt++;
      $error("ack rose without req");
    end

  ack_falls_after_req: assert property (@(posedge CLK) disable iff (!rst_n_i)
    (ack_i && !req_i) |=> !ack_i)
    else begin
      err_cnt++;
      $error("ack did not fall one cycle after req");
    end

  ack_held_with_req: assert property (@(posedge CLK) disable iff (!rst_n_i)
    (ack_i && req_i) |=> ack_i)
    else begin
      err_cnt++;
      $error("ack dropped while req high");
    end

  // Video enable every 7 cycles
  vdc_spacing: assert property (@(posedge CLK) disable iff (!rst_n_i)
    (seen && vdc_ce_i) |-> since == 4'd7)
    else begin
      err_cnt++;
      $error("video enable came early");
    end

  vdc_no_gap: assert property (@(posedge CLK) disable iff (!rst_n_i)
    (seen && !vdc_ce_i) |-> since < 4'd7)
    else begin
      err_cnt++;
      $error("video enable missing");
    end

endmodule

bind scv_top scv_assertions u_sva (
  .CLK, .rst_n_i, .req_i, .ack_i(ack_o), .vdc_ce_i(vdc_ce_o)
);

/* hw/scv_top.sv */
////////////////////////////////////////
// SCV memory bus subsystem
// Init loads and host accesses must not overlap
// No CPU core, VDC or video RAM in here
////////////////////////////////////////

`timescale 1ns/1ps

`include "scv_cfg.svh"

module scv_top (
  input  logic                         CLK,
  input  logic                         rst_n_i,
  // Host port
  input  logic                         req_i,
  input  logic                         we_i,
  input  logic [15:0]                  addr_i,
  input  logic [7:0]                   wdata_i,
  output logic                         ack_o,
  output logic [7:0]                   rdata_o,
  // ROM init stream
  input  scv_init_pkg::scv_init_sel_e  init_sel_i,
  input  scv_init_pkg::scv_init_addr_t init_addr_i,
  input  logic [7:0]                   init_data_i,
  input  logic                         init_valid_i,
  output logic                         vdc_ce_o
);

  import scv_init_pkg::*;

  logic       p1p, p2p, p2n;
  logic       boot_ncs, cart_ncs, wram_ncs;
  logic [7:0] boot_db, cart_db, wram_db;
  logic       boot_we, cart_we;

  cpu_bus_if bus ();

  assign boot_we = init_valid_i & (init_sel_i == INIT_BOOT);
  assign cart_we = init_valid_i & (init_sel_i == INIT_CART);

  scv_clkgen u_clkgen (
    .CLK, .rst_n_i, .p1p_o(p1p), .p1n_o(), .p2p_o(p2p), .p2n_o(p2n), .vdc_ce_o
  );

  scv_bus_ctrl u_bus_ctrl (
    .CLK, .rst_n_i, .p1p_i(p1p), .p2p_i(p2p), .p2n_i(p2n),
    .req_i, .we_i, .addr_i, .wdata_i, .ack_o, .rdata_o, .bus(bus.master)
  );

  scv_decode u_decode (
    .bus(bus.decoder),
    .boot_ncs_o(boot_ncs), .cart_ncs_o(cart_ncs), .wram_ncs_o(wram_ncs),
    .boot_db_i(boot_db), .cart_db_i(cart_db), .wram_db_i(wram_db)
  );

  ////////////////////////////////////////
  // Memories
  ////////////////////////////////////////
  scv_rom #(.AW(`SCV_BOOT_AW)) boot_rom (
    .CLK, .bus(bus.mem), .ncs_i(boot_ncs), .db_o(boot_db),
    .init_addr_i(init_addr_i[`SCV_BOOT_AW-1:0]), .init_data_i, .init_we_i(boot_we)
  );

  scv_rom #(.AW(`SCV_CART_AW)) cart_rom (
    .CLK, .bus(bus.mem), .ncs_i(cart_ncs), .db_o(cart_db),
    .init_addr_i(init_addr_i[`SCV_CART_AW-1:0]), .init_data_i, .init_we_i(cart_we)
  );

  scv_wram u_wram (.CLK, .bus(bus.mem), .ncs_i(wram_ncs), .db_o(wram_db));

endmodule

/* hw/scv_wram.sv */
////////////////////////////////////////
// 128-byte work RAM at FF80-FFFF
// One cycle read latency, hidden by the strobe window
////////////////////////////////////////

`timescale 1ns/1ps

`include "scv_cfg.svh"

module scv_wram (
  input  logic       CLK,
  cpu_bus_if.mem     bus,
  input  logic       ncs_i,
  output logic [7:0] db_o
);

  import scv_map_pkg::*;

  logic [7:0] ram [1 << `SCV_WRAM_AW];
  logic [7:0] dor;

  // Power-up contents are zero
  initial begin
    for (int i = 0; i < (1 << `SCV_WRAM_AW); i++) ram[i] = 8'h00;
  end

  always @(posedge CLK) begin
    dor <= ram[bus.addr.hr.off];
    if (bus.commit && !ncs_i && !bus.wrb) ram[bus.addr.hr.off] <= bus.wdata;
  end

  assign db_o = ncs_i ? SCV_OPEN_BUS : dor;

endmodule

/* hw/scv_rom.sv */
////////////////////////////////////////
// Byte ROM, loaded through the init port
// Bus writes are ignored
////////////////////////////////////////

`timescale 1ns/1ps

module scv_rom #(
  parameter int AW = 12
) (
  input  logic          CLK,
  cpu_bus_if.mem        bus,
  input  logic          ncs_i,
  output logic [7:0]    db_o,
  input  logic [AW-1:0] init_addr_i,
  input  logic [7:0]    init_data_i,
  input  logic          init_we_i
);

  import scv_map_pkg::*;

  logic [7:0] mem [1 << AW];

  // Image load
  always_ff @(posedge CLK) begin
    if (init_we_i) mem[init_addr_i] <= init_data_i;
  end

  // Asynchronous read on the low address bits
  assign db_o = ncs_i ? SCV_OPEN_BUS : mem[bus.addr[AW-1:0]];

endmodule

/* hw/scv_decode.sv */
////////////////////////////////////////
// Address decode and read data mux
// Selects are only active inside a strobe window
// Unmapped and video space reads return open bus
////////////////////////////////////////

`timescale 1ns/1ps

module scv_decode (
  cpu_bus_if.decoder bus,
  output logic       boot_ncs_o,
  output logic       cart_ncs_o,
  output logic       wram_ncs_o,
  input  logic [7:0] boot_db_i,
  input  logic [7:0] cart_db_i,
  input  logic [7:0] wram_db_i
);

  import scv_map_pkg::*;

  scv_region_e region;
  logic        active;

  // WRAM is checked before the cartridge, it sits at the top of that range
  always_comb begin
    region = REG_OPEN;
    if (bus.addr.pg.page == 4'h0)  region = REG_BOOT;
    else if (&bus.addr.hr.hi)      region = REG_WRAM;
    else if (bus.addr.pg.page[3])  region = REG_CART;
  end

  assign active = ~bus.rdb | ~bus.wrb;

  assign boot_ncs_o = ~(active & (region == REG_BOOT));
  assign cart_ncs_o = ~(active & (region == REG_CART));
  assign wram_ncs_o = ~(active & (region == REG_WRAM));

  always_comb begin
    bus.rdata = SCV_OPEN_BUS;
    if (!bus.rdb) begin
      case (region)
        REG_BOOT: bus.rdata = boot_db_i;
        REG_CART: bus.rdata = cart_db_i;
        REG_WRAM: bus.rdata = wram_db_i;
        default:  bus.rdata = SCV_OPEN_BUS;
      endcase
    end
  end

endmodule

/* hw/scv_bus_ctrl.sv */
////////////////////////////////////////
// Host req/ack to CPU bus cycles
// Host must hold addr, we and wdata from req high until ack high
// Holding req high after ack stalls the bus
////////////////////////////////////////

`timescale 1ns/1ps

module scv_bus_ctrl (
  input  logic        CLK,
  input  logic        rst_n_i,
  input  logic        p1p_i,
  input  logic        p2p_i,
  input  logic        p2n_i,
  input  logic        req_i,
  input  logic        we_i,
  input  logic [15:0] addr_i,
  input  logic [7:0]  wdata_i,
  output logic        ack_o,
  output logic [7:0]  rdata_o,
  cpu_bus_if.master   bus
);

  typedef enum logic [1:0] {ST_IDLE, ST_ADDR, ST_STROBE, ST_ACK} state_e;

  state_e state_q;
  logic   we_q;
  logic   accept;
  logic   done;

  assign accept = (state_q == ST_IDLE) & req_i & p1p_i;
  assign done   = (state_q == ST_STROBE) & p2n_i;

  ////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////
  always_ff @(posedge CLK or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
      bus.rdb <= 1'b1;
      bus.wrb <= 1'b1;
    end else begin
      case (state_q)
        ST_IDLE:   if (accept) state_q <= ST_ADDR;
        ST_ADDR: begin
          if (p2p_i) begin  // Open the strobe window
            bus.rdb <= we_q;
            bus.wrb <= ~we_q;
            state_q <= ST_STROBE;
          end
        end
        ST_STROBE: begin
          if (done) begin
            bus.rdb <= 1'b1;
            bus.wrb <= 1'b1;
            state_q <= ST_ACK;
          end
        end
        default:   if (!req_i) state_q <= ST_IDLE;  // Wait for req low
      endcase
    end
  end

  // Request payload and read capture
  always_ff @(posedge CLK) begin
    if (accept) begin
      bus.addr  <= addr_i;
      bus.wdata <= wdata_i;
      we_q      <= we_i;
    end
    if (done && !we_q) rdata_o <= bus.rdata;
  end

  assign bus.commit = done;
  assign ack_o      = (state_q == ST_ACK);

endmodule

/* hw/scv_clkgen.sv */
////////////////////////////////////////
// Two-phase CPU strobes and video enable
// Outputs are one CLK wide pulses, not clocks
////////////////////////////////////////

`timescale 1ns/1ps

`include "scv_cfg.svh"

module scv_clkgen (
  input  logic CLK,
  input  logic rst_n_i,
  output logic p1p_o,
  output logic p1n_o,
  output logic p2p_o,
  output logic p2n_o,
  output logic vdc_ce_o
);

  localparam int CW = $clog2(`SCV_CPU_DIV);
  localparam logic [CW-1:0] LAST    = CW'(`SCV_CPU_DIV - 1);
  localparam logic [CW-1:0] VDC_1ST = CW'(2);
  localparam logic [CW-1:0] VDC_2ND = CW'(2 + `SCV_VDC_DIV);

  logic [CW-1:0] cnt;

  always_ff @(posedge CLK or negedge rst_n_i) begin
    if (!rst_n_i) cnt <= '0;
    else          cnt <= (cnt == LAST) ? '0 : cnt + 1'b1;
  end

  // Phase edges within one CPU cycle
  assign p2n_o = (cnt == CW'(0));
  assign p1p_o = (cnt == CW'(2));
  assign p1n_o = (cnt == CW'(4));
  assign p2p_o = (cnt == CW'(6));

  assign vdc_ce_o = (cnt == VDC_1ST) | (cnt == VDC_2ND);  // Evenly spaced

endmodule

/* hw/cpu_bus_if.sv */
////////////////////////////////////////
// CPU side bus, one master
// Strobes are active low, commit is one CLK wide
////////////////////////////////////////

`timescale 1ns/1ps

interface cpu_bus_if;
  import scv_map_pkg::*;

  scv_addr_u   addr;
  logic        rdb;     // Read strobe
  logic        wrb;     // Write strobe
  logic [7:0]  wdata;
  logic        commit;  // Last cycle of the strobe window
  logic [7:0]  rdata;

  modport master (
    output addr, rdb, wrb, wdata, commit,
    input  rdata
  );

  modport decoder (
    input  addr, rdb, wrb,
    output rdata
  );

  modport mem (input addr, wrb, wdata, commit);

endinterface

/* hw/scv_init_pkg.sv */
////////////////////////////////////////
// ROM init stream types
// Address is wide enough for the largest cartridge image
////////////////////////////////////////

package scv_init_pkg;

  // Target of one init byte
  typedef enum logic [1:0] {INIT_NONE, INIT_BOOT, INIT_CART} scv_init_sel_e;

  // Byte address within the selected image
  typedef logic [16:0] scv_init_addr_t;

endpackage

/* hw/scv_map_pkg.sv */
////////////////////////////////////////
// CPU memory map types
// Video space 2000-3FFF is not modelled and reads as open bus
////////////////////////////////////////

package scv_map_pkg;

  // Page view: boot ROM and unmapped pages
  typedef struct packed {
    logic [3:0]  page;
    logic [11:0] offset;
  } scv_page_addr_t;

  // High-RAM view: FF80-FFFF when hi is all ones
  typedef struct packed {
    logic [8:0] hi;
    logic [6:0] off;
  } scv_hram_addr_t;

  // One CPU address, two ways to decode it
  typedef union packed {
    scv_page_addr_t pg;
    scv_hram_addr_t hr;
  } scv_addr_u;

  typedef enum logic [1:0] {REG_BOOT, REG_CART, REG_WRAM, REG_OPEN} scv_region_e;

  localparam logic [7:0] SCV_OPEN_BUS = 8'hFF;  // Undriven data bus pulls high

endpackage

/* hw/scv_cfg.svh */
////////////////////////////////////////
// Clock divider and memory size constants
// The CPU divider must stay above 6 so that all four strobes fit in one cycle
// The video enable lands twice per CPU cycle
////////////////////////////////////////

`ifndef SCV_CFG_SVH
`define SCV_CFG_SVH

// Clock dividers
`define SCV_CPU_DIV 14  // CLK cycles per CPU cycle
`define SCV_VDC_DIV 7   // CLK cycles per video clock enable

////////////////////////////////////////
// Memory address widths
////////////////////////////////////////
`define SCV_BOOT_AW 12  // 4 KiB boot ROM
`define SCV_CART_AW 15  // 32 KiB cartridge window
`define SCV_WRAM_AW 7   // 128 B work RAM

`endif
